// ==== common/lvdc_timing_pkg.sv ====
package lvdc_timing_pkg;

    // Widest word the section is built for.
    localparam int MAX_WORD_W = 32;

    // Counts one word of bit times plus two drain cycles.
    localparam int BIT_INDEX_W = $clog2(MAX_WORD_W + 2);

    // Position of the current bit time within the word.
    typedef logic [BIT_INDEX_W-1:0] bit_index_t;

    // Bit time markers.
    typedef struct packed {
        logic active;  // A bit time is running.
        logic first;   // Least significant bit time.
        logic last;    // Most significant bit time.
    } bit_slot_t;

endpackage

// ==== common/lvdc_arith_pkg.sv ====
package lvdc_arith_pkg;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,  // acc + mem
        OP_SUB = 3'd1,  // acc - mem
        OP_RSU = 3'd2,  // mem - acc
        OP_AND = 3'd3,  // acc & mem
        OP_CLA = 3'd4   // Clear and add, loads mem.
    } arith_op_t;

    // Result status flags.
    typedef struct packed {
        logic zero;
        logic negative;
        logic overflow;
    } arith_status_t;

    // One bit of each operand together with its bit time markers.
    typedef struct packed {
        logic                       acc_bit;
        logic                       mem_bit;
        lvdc_timing_pkg::bit_slot_t slot;
    } serial_operand_t;

    // One result bit from the serial unit.
    // The status is meaningful only on the last bit.
    typedef struct packed {
        logic          res_bit;
        logic          valid;
        logic          last;
        arith_status_t status;
    } serial_result_t;

endpackage

// ==== logic/bit_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bit_timer #(
    parameter int WORD_W = 26
) (
    input  logic                       sim_clk,
    input  logic                       rst_n,
    input  logic                       start,
    output lvdc_timing_pkg::bit_slot_t slot,
    output logic                       busy
);

    localparam lvdc_timing_pkg::bit_index_t WORD_LEN  = lvdc_timing_pkg::bit_index_t'(WORD_W);
    localparam lvdc_timing_pkg::bit_index_t LAST_BIT  = lvdc_timing_pkg::bit_index_t'(WORD_W - 1);
    localparam lvdc_timing_pkg::bit_index_t DRAIN_END = lvdc_timing_pkg::bit_index_t'(WORD_W + 1);

    lvdc_timing_pkg::bit_index_t bit_cnt;

    // The count keeps running past the word so that busy covers the
    // serializer and unit stages as well.
    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
        end else if (busy) begin
            if (bit_cnt == DRAIN_END)
                busy <= 1'b0;  // Falls together with done.
            bit_cnt <= bit_cnt + 1'b1;
        end else if (start) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
        end
    end

    assign slot.active = busy && (bit_cnt < WORD_LEN);
    assign slot.first  = slot.active && (bit_cnt == '0);
    assign slot.last   = slot.active && (bit_cnt == LAST_BIT);

    // A start during an operation would be dropped here but reload the
    // serializer and the unit's opcode.
    a_no_start_when_busy: assert property (
        @(posedge sim_clk) disable iff (!rst_n) start |-> !busy
    ) else $error("start received while the arithmetic section is busy");

endmodule

`default_nettype wire

// ==== logic/operand_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_serializer #(
    parameter int WORD_W = 26
) (
    input  logic                            sim_clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic [WORD_W-1:0]               acc_in,
    input  logic [WORD_W-1:0]               mem_in,
    input  lvdc_timing_pkg::bit_slot_t      slot,
    output lvdc_arith_pkg::serial_operand_t bits
);

    logic [WORD_W-1:0] acc_sr;
    logic [WORD_W-1:0] mem_sr;

    // Both operand registers shift toward bit 0, one place per bit time.
    always_ff @(posedge sim_clk) begin
        if (start) begin
            acc_sr <= acc_in;
            mem_sr <= mem_in;
        end else if (slot.active) begin
            acc_sr <= {1'b0, acc_sr[WORD_W-1:1]};
            mem_sr <= {1'b0, mem_sr[WORD_W-1:1]};
        end
    end

    // Output stage, one cycle behind the slot that selected the bit.
    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            bits <= '0;
        end else begin
            bits.slot <= slot;
            if (slot.active) begin
                bits.acc_bit <= acc_sr[0];
                bits.mem_bit <= mem_sr[0];
            end else begin
                bits.acc_bit <= 1'b0;  // Quiet between words.
                bits.mem_bit <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== arithmetic/serial_arith_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module serial_arith_unit (
    input  logic                            sim_clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  lvdc_arith_pkg::arith_op_t       op,
    input  lvdc_arith_pkg::serial_operand_t bits,
    output lvdc_arith_pkg::serial_result_t  rbits
);

    lvdc_arith_pkg::arith_op_t     op_q;
    lvdc_arith_pkg::arith_status_t status_next;

    logic carry_q;  // Carry between bit times.
    logic zero_q;   // Stays set while every result bit so far is 0.
    logic run_q;    // An operation has started and its last bit is not out yet.

    logic x_bit;
    logic y_bit;
    logic sum_bit;
    logic carry_out;
    logic res_bit;
    logic arith_op;

    // Operand steering. Subtraction adds the inverted subtrahend, with
    // the carry preset to 1 for the two's complement.
    always_comb begin
        x_bit = bits.acc_bit;
        y_bit = bits.mem_bit;
        case (op_q)
            lvdc_arith_pkg::OP_SUB: y_bit = ~bits.mem_bit;
            lvdc_arith_pkg::OP_RSU: begin
                x_bit = bits.mem_bit;
                y_bit = ~bits.acc_bit;
            end
            default: ;
        endcase
    end

    assign sum_bit   = x_bit ^ y_bit ^ carry_q;
    assign carry_out = (x_bit & y_bit) | (carry_q & (x_bit ^ y_bit));

    always_comb begin
        case (op_q)
            lvdc_arith_pkg::OP_AND: res_bit = bits.acc_bit & bits.mem_bit;
            lvdc_arith_pkg::OP_CLA: res_bit = bits.mem_bit;
            default:                res_bit = sum_bit;
        endcase
    end

    assign arith_op = (op_q == lvdc_arith_pkg::OP_ADD) ||
                      (op_q == lvdc_arith_pkg::OP_SUB) ||
                      (op_q == lvdc_arith_pkg::OP_RSU);

    // On the sign bit the carry in and carry out disagree on overflow.
    assign status_next.zero     = zero_q & ~res_bit;
    assign status_next.negative = res_bit;
    assign status_next.overflow = arith_op & (carry_q ^ carry_out);

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            op_q    <= lvdc_arith_pkg::OP_ADD;
            carry_q <= 1'b0;
            zero_q  <= 1'b0;
            run_q   <= 1'b0;
        end else if (start) begin
            op_q    <= op;
            carry_q <= (op == lvdc_arith_pkg::OP_SUB) || (op == lvdc_arith_pkg::OP_RSU);
            zero_q  <= 1'b1;
            run_q   <= 1'b1;
        end else begin
            if (bits.slot.active) begin
                carry_q <= carry_out;
                zero_q  <= status_next.zero;
            end
            if (rbits.valid && rbits.last)
                run_q <= 1'b0;  // Last result bit has gone out.
        end
    end

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            rbits <= '0;
        end else begin
            rbits.res_bit <= bits.slot.active & res_bit;
            rbits.valid   <= bits.slot.active;
            rbits.last    <= bits.slot.active & bits.slot.last;
            rbits.status  <= bits.slot.last ? status_next : '0;
        end
    end

    // Result bits only flow between a start and the end of its word.
    a_valid_in_operation: assert property (
        @(posedge sim_clk) disable iff (!rst_n) rbits.valid |-> run_q
    ) else $error("result bit valid outside an operation");

    a_sub_carry_preset: assert property (
        @(posedge sim_clk) disable iff (!rst_n)
            (bits.slot.active && bits.slot.first &&
             (op_q == lvdc_arith_pkg::OP_SUB || op_q == lvdc_arith_pkg::OP_RSU))
            |-> carry_q
    ) else $error("carry not preset on the first bit of a subtraction");

endmodule

`default_nettype wire

// ==== logic/result_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_collector #(
    parameter int WORD_W = 26
) (
    input  logic                           sim_clk,
    input  logic                           rst_n,
    input  lvdc_arith_pkg::serial_result_t rbits,
    output logic [WORD_W-1:0]              result,
    output lvdc_arith_pkg::arith_status_t  status,
    output logic                           done
);

    logic [WORD_W-1:0] gather_sr;
    logic [WORD_W-1:0] gather_next;

    // Bits come in LSB first, so each new bit enters at the top and the
    // word is in place once the last bit has arrived.
    assign gather_next = {rbits.res_bit, gather_sr[WORD_W-1:1]};

    always_ff @(posedge sim_clk) begin
        if (rbits.valid)
            gather_sr <= gather_next;
    end

    // Result and status hold until the next operation completes.
    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            result <= '0;
            status <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (rbits.valid && rbits.last) begin
                result <= gather_next;
                status <= rbits.status;  // Negative is the sign bit from the unit.
                done   <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/arith_section_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module arith_section_top #(
    parameter int WORD_W = 26
) (
    input  logic                          sim_clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  lvdc_arith_pkg::arith_op_t     op,
    input  logic [WORD_W-1:0]             acc_in,
    input  logic [WORD_W-1:0]             mem_in,
    output logic                          busy,
    output logic                          done,
    output logic [WORD_W-1:0]             result,
    output lvdc_arith_pkg::arith_status_t status
);

    lvdc_timing_pkg::bit_slot_t      slot;
    lvdc_arith_pkg::serial_operand_t bits;
    lvdc_arith_pkg::serial_result_t  rbits;

    bit_timer #(.WORD_W(WORD_W)) u_bit_timer (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .start   (start),
        .slot    (slot),
        .busy    (busy)
    );

    operand_serializer #(.WORD_W(WORD_W)) u_operand_serializer (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .start   (start),
        .acc_in  (acc_in),
        .mem_in  (mem_in),
        .slot    (slot),
        .bits    (bits)
    );

    serial_arith_unit u_serial_arith_unit (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .start   (start),
        .op      (op),
        .bits    (bits),
        .rbits   (rbits)
    );

    result_collector #(.WORD_W(WORD_W)) u_result_collector (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .rbits   (rbits),
        .result  (result),
        .status  (status),
        .done    (done)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic sim_clk,
    output logic rst_n
);

    initial begin
        sim_clk = 1'b0;
        forever #HALF_PERIOD sim_clk = ~sim_clk;
    end

    // Reset is released on a falling edge, away from the sampling edge.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sim_clk);
        @(negedge sim_clk);
        rst_n = 1'b1;
    end

endmodule

// ==== testbench/tb_arith_section.sv ====
`timescale 1ns/1ps

module tb_arith_section;

    localparam int W = 26;
    localparam int DONE_LIMIT = W + 10;  // Cycles to wait for done before giving up.
    localparam int NUM_OPS = 68;
    localparam int WATCHDOG_NS = NUM_OPS * (W + 4) * 8 + 2000;

    logic sim_clk;
    logic rst_n;
    logic start;
    lvdc_arith_pkg::arith_op_t op;
    logic [W-1:0] acc_in;
    logic [W-1:0] mem_in;
    logic busy;
    logic done;
    logic [W-1:0] result;
    lvdc_arith_pkg::arith_status_t status;

    logic [31:0] lcg_state = 32'd68431;
    logic [W-1:0] got_result;
    lvdc_arith_pkg::arith_status_t got_status;
    int done_edges;
    logic busy_held;
    int test_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    tb_clock_gen clock_gen (
        .sim_clk (sim_clk),
        .rst_n   (rst_n)
    );

    arith_section_top #(.WORD_W(W)) UUT (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .start   (start),
        .op      (op),
        .acc_in  (acc_in),
        .mem_in  (mem_in),
        .busy    (busy),
        .done    (done),
        .result  (result),
        .status  (status)
    );

    function automatic logic [W-1:0] rand_word();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:32-W];  // Upper bits have the longer period.
    endfunction

    function automatic logic [W-1:0] expected_result(input lvdc_arith_pkg::arith_op_t op_sel,
                                                     input logic [W-1:0] acc,
                                                     input logic [W-1:0] mem);
        case (op_sel)
            lvdc_arith_pkg::OP_ADD: return acc + mem;
            lvdc_arith_pkg::OP_SUB: return acc - mem;
            lvdc_arith_pkg::OP_RSU: return mem - acc;
            lvdc_arith_pkg::OP_AND: return acc & mem;
            default:                return mem;
        endcase
    endfunction

    function automatic lvdc_arith_pkg::arith_status_t expected_status(
        input lvdc_arith_pkg::arith_op_t op_sel,
        input logic [W-1:0] acc,
        input logic [W-1:0] mem
    );
        logic [W-1:0] res;
        lvdc_arith_pkg::arith_status_t st;
        res = expected_result(op_sel, acc, mem);
        st.zero = (res == '0);
        st.negative = res[W-1];
        // Signed overflow from the operand and result signs.
        case (op_sel)
            lvdc_arith_pkg::OP_ADD:
                st.overflow = (acc[W-1] == mem[W-1]) && (res[W-1] != acc[W-1]);
            lvdc_arith_pkg::OP_SUB:
                st.overflow = (acc[W-1] != mem[W-1]) && (res[W-1] != acc[W-1]);
            lvdc_arith_pkg::OP_RSU:
                st.overflow = (mem[W-1] != acc[W-1]) && (res[W-1] != mem[W-1]);
            default:
                st.overflow = 1'b0;
        endcase
        return st;
    endfunction

    task automatic compare_word(input logic [W-1:0] got, input logic [W-1:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s result is %h, expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic compare_status(input lvdc_arith_pkg::arith_status_t got,
                                  input lvdc_arith_pkg::arith_status_t exp,
                                  input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s status z/n/v is %b%b%b, expected %b%b%b", $time,
                     what, got.zero, got.negative, got.overflow,
                     exp.zero, exp.negative, exp.overflow);
            test_errors++;
        end
    endtask

    // Pulses start and waits for done. Counts edges after the start edge.
    task automatic run_op(input lvdc_arith_pkg::arith_op_t op_sel, input logic [W-1:0] acc,
                          input logic [W-1:0] mem, input bit back_to_back);
        if (!back_to_back)
            @(negedge sim_clk);
        start = 1'b1;
        op = op_sel;
        acc_in = acc;
        mem_in = mem;
        @(negedge sim_clk);
        start = 1'b0;
        done_edges = 0;
        busy_held = 1'b1;
        while (!done && done_edges < DONE_LIMIT) begin
            if (!busy)
                busy_held = 1'b0;
            @(negedge sim_clk);
            done_edges++;
        end
        if (!done) begin
            $display("done did not arrive within %0d cycles at %0t", DONE_LIMIT, $time);
            test_errors++;
        end
        got_result = result;
        got_status = status;
    endtask

    task automatic check_op(input lvdc_arith_pkg::arith_op_t op_sel, input logic [W-1:0] acc,
                            input logic [W-1:0] mem, input string what,
                            input bit back_to_back = 1'b0);
        run_op(op_sel, acc, mem, back_to_back);
        compare_word(got_result, expected_result(op_sel, acc, mem), what);
        compare_status(got_status, expected_status(op_sel, acc, mem), what);
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: pass", name);
            tests_passed++;
        end else begin
            $display("test %s: fail with %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic reset_values();
        if (busy !== 1'b0 || done !== 1'b0) begin
            $display("mismatch at %0t: busy or done is not low after reset", $time);
            test_errors++;
        end
        compare_word(result, '0, "reset");
        compare_status(status, '0, "reset");
        finish_test("reset_state");
    endtask

    task automatic add_random_pairs();
        for (int i = 0; i < 20; i++)
            check_op(lvdc_arith_pkg::OP_ADD, rand_word(), rand_word(), "add");
        finish_test("add_random");
    endtask

    task automatic subtract_pairs();
        logic [W-1:0] same;
        for (int i = 0; i < 8; i++) begin
            check_op(lvdc_arith_pkg::OP_SUB, rand_word(), rand_word(), "sub");
            check_op(lvdc_arith_pkg::OP_RSU, rand_word(), rand_word(), "rsu");
        end
        same = rand_word();
        check_op(lvdc_arith_pkg::OP_SUB, same, same, "sub equal");
        check_op(lvdc_arith_pkg::OP_RSU, same, same, "rsu equal");
        if (!got_status.zero || got_status.negative) begin
            $display("mismatch at %0t: equal operands did not give a zero, non-negative result",
                     $time);
            test_errors++;
        end
        finish_test("subtract");
    endtask

    task automatic overflow_corners();
        logic [W-1:0] max_pos;
        logic [W-1:0] max_neg;
        logic [W-1:0] a;
        logic [W-1:0] b;
        max_pos = {1'b0, {(W-1){1'b1}}};
        max_neg = {1'b1, {(W-1){1'b0}}};
        check_op(lvdc_arith_pkg::OP_ADD, max_pos, W'(1), "max positive plus one");
        check_op(lvdc_arith_pkg::OP_SUB, max_neg, W'(1), "most negative minus one");
        check_op(lvdc_arith_pkg::OP_RSU, W'(1), max_neg, "reverse most negative minus one");
        for (int i = 0; i < 8; i++) begin
            a = rand_word();
            b = rand_word();
            b[W-1] = ~a[W-1];
            check_op(lvdc_arith_pkg::OP_ADD, a, b, "mixed sign add");
            if (got_status.overflow) begin
                $display("mismatch at %0t: overflow was set by a mixed-sign add", $time);
                test_errors++;
            end
        end
        finish_test("overflow");
    endtask

    task automatic logic_and_load();
        logic [W-1:0] ones;
        ones = '1;
        for (int i = 0; i < 6; i++) begin
            check_op(lvdc_arith_pkg::OP_AND, rand_word(), rand_word(), "and");
            check_op(lvdc_arith_pkg::OP_CLA, rand_word(), rand_word(), "cla");
        end
        check_op(lvdc_arith_pkg::OP_AND, '0, ones, "and zeros");
        check_op(lvdc_arith_pkg::OP_AND, ones, ones, "and ones");
        check_op(lvdc_arith_pkg::OP_AND, ones, '0, "and ones with zeros");
        check_op(lvdc_arith_pkg::OP_CLA, ones, '0, "cla zeros");
        check_op(lvdc_arith_pkg::OP_CLA, '0, ones, "cla ones");
        finish_test("logic_ops");
    endtask

    task automatic latency_and_restart();
        check_op(lvdc_arith_pkg::OP_ADD, rand_word(), rand_word(), "timed add");
        if (done_edges != W + 2) begin
            $display("done came %0d cycles after start instead of %0d", done_edges, W + 2);
            test_errors++;
        end
        if (!busy_held || busy) begin
            $display("mismatch at %0t: busy was not high from start until done", $time);
            test_errors++;
        end
        // Start again on the very next cycle after done.
        check_op(lvdc_arith_pkg::OP_SUB, rand_word(), rand_word(), "back to back", 1'b1);
        if (done_edges != W + 2) begin
            $display("back-to-back start gave latency %0d instead of %0d", done_edges, W + 2);
            test_errors++;
        end
        finish_test("timing");
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        start = 1'b0;
        op = lvdc_arith_pkg::OP_ADD;
        acc_in = '0;
        mem_in = '0;
        @(posedge rst_n);
        @(negedge sim_clk);
        reset_values();
        add_random_pairs();
        subtract_pairs();
        overflow_corners();
        logic_and_load();
        latency_and_restart();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== arith_section_top.f ====
common/lvdc_timing_pkg.sv
common/lvdc_arith_pkg.sv
logic/bit_timer.sv
logic/operand_serializer.sv
arithmetic/serial_arith_unit.sv
logic/result_collector.sv
logic/arith_section_top.sv
testbench/tb_clock_gen.sv
testbench/tb_arith_section.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the arithmetic section testbench with Verilator and runs it.

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_arith_section
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator is not on the PATH"
    exit 1
fi

verilator --binary --timing --assert \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -f arith_section_top.f
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

if ! grep -q "Testbench passed" "$LOG"; then
    echo "simulation ended without a final report, see $LOG"
    exit 1
fi

echo "simulation finished without errors"
exit 0
